// ==== common/au_pkg.sv ====
`default_nettype none

package au_pkg;

	// ----------------------------------------------------------------------
	// Register file and datapath widths
	// ----------------------------------------------------------------------
	localparam int NUM_REGS = 16;

	typedef logic [31:0] word_t;                    // Register, operand and result word
	typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t; // Register index
	typedef logic [32:0] sum_t;                     // Word with carry or borrow on top
	typedef logic [4:0] shamt_t;                    // Shift and rotate amount
	typedef logic [5:0] cnt_t;                      // Population count, 0 to 32

	// ----------------------------------------------------------------------
	// Operation codes
	// ----------------------------------------------------------------------
	typedef enum logic [3:0] {
		AU_ADD   = 4'b0000,
		AU_SUB   = 4'b0001,
		AU_MUL   = 4'b0010, // Sign-magnitude multiply
		AU_UMUL  = 4'b0011,
		AU_DIV   = 4'b0100, // Divide and modulo return zero
		AU_UDIV  = 4'b0101,
		AU_MOD   = 4'b0110,
		AU_UMOD  = 4'b0111,
		AU_SHR   = 4'b1000,
		AU_SHL   = 4'b1001,
		AU_ROR   = 4'b1010,
		AU_ROL   = 4'b1011,
		AU_PCNT  = 4'b1100, // Ones
		AU_PCNTZ = 4'b1101, // Zeros
		AU_PCNTC = 4'b1110, // Bit changes between neighbours
		AU_RND   = 4'b1111
	} au_op_e;

	// ----------------------------------------------------------------------
	// Random number generator
	// ----------------------------------------------------------------------
	localparam word_t LFSR_TAPS = 32'h8020_0003; // Galois feedback mask
	localparam word_t LFSR_SEED = 32'h0000_0001;

endpackage

`default_nettype wire

// ==== common/au_issue_if.sv ====
`default_nettype none

interface au_issue_if
	import au_pkg::*;
();

	logic     valid; // One cycle per instruction
	au_op_e   op;
	reg_idx_t rd;
	word_t    a;
	word_t    b;

	modport issue (
		output valid,
		output op,
		output rd,
		output a,
		output b
	);

	modport exec (
		input valid,
		input op,
		input rd,
		input a,
		input b
	);

endinterface

`default_nettype wire

// ==== verilog/reg_file.sv ====
`default_nettype none

module reg_file
	import au_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     load_valid,
	input  reg_idx_t load_rd,
	input  word_t    load_data,
	input  logic     wb_valid,
	input  reg_idx_t wb_rd,
	input  word_t    wb_data,
	input  reg_idx_t ra,
	input  reg_idx_t rb,
	output word_t    ra_data,
	output word_t    rb_data
);

	word_t regs [1:NUM_REGS-1]; // Register zero has no storage

	// Writeback is visible in the cycle it is presented
	function automatic word_t read_port(input reg_idx_t idx);
		if (idx == '0)
			return '0;
		if (wb_valid && (wb_rd == idx))
			return wb_data;
		return regs[idx];
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 1; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else
		begin
			if (load_valid && (load_rd != '0))
				regs[load_rd] <= load_data; // Host load
			if (wb_valid && (wb_rd != '0))
				regs[wb_rd] <= wb_data; // Overrides a load to the same register
		end
	end

	always_comb
	begin
		ra_data = read_port(ra);
		rb_data = read_port(rb);
	end

endmodule

`default_nettype wire

// ==== verilog/issue_stage.sv ====
`default_nettype none

module issue_stage
	import au_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     issue_valid,
	input  au_op_e   issue_op,
	input  reg_idx_t issue_rd,
	input  reg_idx_t issue_ra,
	input  reg_idx_t issue_rb,
	input  word_t    ra_data,
	input  word_t    rb_data,
	input  logic     fwd_valid,
	input  reg_idx_t fwd_rd,
	input  word_t    fwd_data,
	output reg_idx_t ra,
	output reg_idx_t rb,
	au_issue_if.issue iss
);

	word_t op_a;
	word_t op_b;

	// In-flight AU result is newer than anything in the register file
	function automatic word_t pick_operand(input reg_idx_t idx, input word_t rf_data);
		if (fwd_valid && (idx != '0) && (idx == fwd_rd))
			return fwd_data;
		return rf_data;
	endfunction

	assign ra = issue_ra; // Read indices straight from the instruction
	assign rb = issue_rb;

	always_comb
	begin
		op_a = pick_operand(issue_ra, ra_data);
		op_b = pick_operand(issue_rb, rb_data);
	end

	// ----------------------------------------------------------------------
	// Issue register into the AU stage
	// ----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
			iss.valid <= 1'b0;
		else
			iss.valid <= issue_valid;
	end

	always_ff @(posedge clk)
	begin
		if (issue_valid)
		begin
			iss.op <= issue_op;
			iss.rd <= issue_rd;
			iss.a  <= op_a;
			iss.b  <= op_b;
		end
	end

endmodule

`default_nettype wire

// ==== au/rnd_lfsr.sv ====
`default_nettype none

module rnd_lfsr
	import au_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  rnd_step,
	output word_t rnd_value
);

	word_t state;
	word_t next_state;

	// Galois form shifting right
	always_comb
	begin
		next_state = state >> 1;
		if (state[0])
			next_state = next_state ^ LFSR_TAPS; // Feedback from the bit shifted out
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= LFSR_SEED;
		else if (rnd_step)
			state <= next_state; // Once per executed RND
	end

	assign rnd_value = state;

endmodule

`default_nettype wire

// ==== au/au.sv ====
`default_nettype none

module au
	import au_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  word_t    rnd_value,
	au_issue_if.exec ex,
	output logic     fwd_valid,
	output reg_idx_t fwd_rd,
	output word_t    fwd_data,
	output logic     wb_valid,
	output reg_idx_t wb_rd,
	output word_t    wb_data,
	output logic     carry,
	output logic     rnd_step
);

	sum_t        add_sum;   // Carry out in bit 32
	sum_t        sub_diff;  // Borrow out in bit 32
	logic [30:0] mag_prod;  // Low bits of the magnitude product
	shamt_t      sh;
	logic [63:0] rot_src;
	logic [63:0] ror_full;
	logic [63:0] rol_full;
	word_t       chg;       // Set where a bit differs from its upper neighbour
	word_t       res;
	logic        res_carry;

	// Ones in one nibble
	function automatic logic [2:0] pcnt4(input logic [3:0] x);
		return 3'(x[0]) + 3'(x[1]) + 3'(x[2]) + 3'(x[3]);
	endfunction

	// Sum of eight nibble counts
	function automatic cnt_t count_ones(input word_t x);
		cnt_t n;
		n = '0;
		for (int i = 0; i < 8; i++)
			n = n + cnt_t'(pcnt4(x[4*i +: 4]));
		return n;
	endfunction

	// ----------------------------------------------------------------------
	// Operand preparation
	// ----------------------------------------------------------------------
	assign add_sum  = {1'b0, ex.a} + {1'b0, ex.b};
	assign sub_diff = {1'b0, ex.a} - {1'b0, ex.b};
	assign mag_prod = ex.a[30:0] * ex.b[30:0];
	assign sh       = ex.b[4:0];
	assign rot_src  = {ex.a, ex.a}; // Doubled word makes the rotate a plain shift
	assign ror_full = rot_src >> sh;
	assign rol_full = rot_src << sh;
	assign chg      = {1'b0, ex.a[31:1] ^ ex.a[30:0]};

	// ----------------------------------------------------------------------
	// Operation select
	// ----------------------------------------------------------------------
	always_comb
	begin
		res       = '0;
		res_carry = 1'b0; // Only ADD and SUB set it
		case (ex.op)
			AU_ADD:
			begin
				res       = add_sum[31:0];
				res_carry = add_sum[32];
			end
			AU_SUB:
			begin
				res       = sub_diff[31:0];
				res_carry = sub_diff[32];
			end
			AU_MUL:   res = {ex.a[31] ^ ex.b[31], mag_prod};
			AU_UMUL:  res = ex.a * ex.b; // Low half of the product
			AU_SHR:   res = ex.a >> sh;
			AU_SHL:   res = ex.a << sh;
			AU_ROR:   res = ror_full[31:0];
			AU_ROL:   res = rol_full[63:32];
			AU_PCNT:  res = word_t'(count_ones(ex.a));
			AU_PCNTZ: res = word_t'(count_ones(~ex.a));
			AU_PCNTC: res = word_t'(count_ones(chg));
			AU_RND:   res = rnd_value;
			default:  res = '0; // Divide and modulo codes
		endcase
	end

	// Bypass to the issue stage
	assign fwd_valid = ex.valid;
	assign fwd_rd    = ex.rd;
	assign fwd_data  = res;

	assign rnd_step = ex.valid && (ex.op == AU_RND); // LFSR moves with the read

	// ----------------------------------------------------------------------
	// Writeback register
	// ----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wb_valid <= 1'b0;
			carry    <= 1'b0;
		end
		else
		begin
			wb_valid <= ex.valid;
			if (ex.valid)
				carry <= res_carry;
		end
	end

	always_ff @(posedge clk)
	begin
		if (ex.valid)
		begin
			wb_rd   <= ex.rd;
			wb_data <= res;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/au_pipe_top.sv ====
`default_nettype none

module au_pipe_top
	import au_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     issue_valid,
	input  au_op_e   issue_op,
	input  reg_idx_t issue_rd,
	input  reg_idx_t issue_ra,
	input  reg_idx_t issue_rb,
	input  logic     load_valid,
	input  reg_idx_t load_rd,
	input  word_t    load_data,
	output logic     result_valid,
	output reg_idx_t result_rd,
	output word_t    result,
	output logic     carry
);

	reg_idx_t ra;
	reg_idx_t rb;
	word_t    ra_data;
	word_t    rb_data;
	logic     fwd_valid;
	reg_idx_t fwd_rd;
	word_t    fwd_data;
	logic     rnd_step;
	word_t    rnd_value;

	au_issue_if iss_if ();

	// ----------------------------------------------------------------------
	// Pipeline stages
	// ----------------------------------------------------------------------
	reg_file u_reg_file (
		.clk        (clk),
		.rst        (rst),
		.load_valid (load_valid),
		.load_rd    (load_rd),
		.load_data  (load_data),
		.wb_valid   (result_valid), // Writeback shares the result outputs
		.wb_rd      (result_rd),
		.wb_data    (result),
		.ra         (ra),
		.rb         (rb),
		.ra_data    (ra_data),
		.rb_data    (rb_data)
	);

	issue_stage u_issue_stage (
		.clk         (clk),
		.rst         (rst),
		.issue_valid (issue_valid),
		.issue_op    (issue_op),
		.issue_rd    (issue_rd),
		.issue_ra    (issue_ra),
		.issue_rb    (issue_rb),
		.ra_data     (ra_data),
		.rb_data     (rb_data),
		.fwd_valid   (fwd_valid),
		.fwd_rd      (fwd_rd),
		.fwd_data    (fwd_data),
		.ra          (ra),
		.rb          (rb),
		.iss         (iss_if.issue)
	);

	au u_au (
		.clk       (clk),
		.rst       (rst),
		.rnd_value (rnd_value),
		.ex        (iss_if.exec),
		.fwd_valid (fwd_valid),
		.fwd_rd    (fwd_rd),
		.fwd_data  (fwd_data),
		.wb_valid  (result_valid),
		.wb_rd     (result_rd),
		.wb_data   (result),
		.carry     (carry),
		.rnd_step  (rnd_step)
	);

	rnd_lfsr u_rnd_lfsr (
		.clk       (clk),
		.rst       (rst),
		.rnd_step  (rnd_step),
		.rnd_value (rnd_value)
	);

endmodule

`default_nettype wire

// ==== dv/au_pipe_properties.sv ====
`default_nettype none

module au_pipe_properties
	import au_pkg::*;
(
	input logic     clk,
	input logic     rst,
	input logic     issue_valid,
	input reg_idx_t issue_rd,
	input logic     result_valid,
	input reg_idx_t result_rd,
	input logic     iss_valid
);

	timeunit 1ns;
	timeprecision 100ps;

	// ----------------------------------------------------------------------
	// Pipeline latency of two edges from issue to result
	// ----------------------------------------------------------------------
	issue_gives_result: assert property (@(posedge clk) disable iff (rst)
		issue_valid |-> ##2 result_valid)
	else
	begin
		$error("result_valid missing two cycles after issue_valid");
		au_pipe_tb.prop_fails++;
	end

	result_needs_issue: assert property (@(posedge clk) disable iff (rst)
		result_valid |-> $past(issue_valid, 2))
	else
	begin
		$error("result_valid without issue_valid two cycles earlier");
		au_pipe_tb.prop_fails++;
	end

	result_rd_follows: assert property (@(posedge clk) disable iff (rst)
		issue_valid |-> ##2 (result_rd == $past(issue_rd, 2)))
	else
	begin
		$error("result_rd differs from the issued rd");
		au_pipe_tb.prop_fails++;
	end

	// Both valid flags cleared by reset
	reset_clears_valid: assert property (@(posedge clk)
		rst |=> (!result_valid && !iss_valid))
	else
	begin
		$error("valid still set in the cycle after rst");
		au_pipe_tb.prop_fails++;
	end

endmodule

`default_nettype wire

// ==== dv/au_pipe_tb.sv ====
`default_nettype none

module au_pipe_tb
	import au_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 40;
	localparam int TEST_CYCLES = 45 + 40 + 45 + 35 + 25 + 30; // Per test in run order
	localparam int WATCHDOG_NS = (TEST_CYCLES + 2 + 50) * CLK_PERIOD;

	logic     clk;
	logic     rst;
	logic     issue_valid;
	au_op_e   issue_op;
	reg_idx_t issue_rd;
	reg_idx_t issue_ra;
	reg_idx_t issue_rb;
	logic     load_valid;
	reg_idx_t load_rd;
	word_t    load_data;
	logic     result_valid;
	reg_idx_t result_rd;
	word_t    result;
	logic     carry;

	word_t    model_regs [NUM_REGS];
	word_t    lfsr_model;
	word_t    exp_data_q [$];
	reg_idx_t exp_rd_q [$];
	logic     exp_carry_q [$];
	int       errors = 0;
	int       checks = 0;
	int       prop_fails = 0; // Raised by the bound assertions

	au_pipe_top dut_i (
		.clk          (clk),
		.rst          (rst),
		.issue_valid  (issue_valid),
		.issue_op     (issue_op),
		.issue_rd     (issue_rd),
		.issue_ra     (issue_ra),
		.issue_rb     (issue_rb),
		.load_valid   (load_valid),
		.load_rd      (load_rd),
		.load_data    (load_data),
		.result_valid (result_valid),
		.result_rd    (result_rd),
		.result       (result),
		.carry        (carry)
	);

	bind au_pipe_top au_pipe_properties props_i (
		.clk          (clk),
		.rst          (rst),
		.issue_valid  (issue_valid),
		.issue_rd     (issue_rd),
		.result_valid (result_valid),
		.result_rd    (result_rd),
		.iss_valid    (iss_if.valid)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// Reference model
	// ----------------------------------------------------------------------
	function automatic word_t lfsr_next(input word_t s);
		if (s[0])
			return (s >> 1) ^ LFSR_TAPS;
		return s >> 1;
	endfunction

	function automatic void model_exec(input au_op_e op, input word_t a, input word_t b,
			output word_t r, output logic c);
		logic [63:0] p;
		int s;
		int n;
		r = '0;
		c = 1'b0;
		s = b[4:0];
		n = 0;
		case (op)
			AU_ADD:
			begin
				r = a + b;
				c = (r < a); // Carry out of bit 31
			end
			AU_SUB:
			begin
				r = a - b;
				c = (a < b); // Borrow
			end
			AU_MUL:
			begin
				p = a[30:0] * b[30:0];
				r = {a[31] ^ b[31], p[30:0]};
			end
			AU_UMUL:
			begin
				p = a * b;
				r = p[31:0];
			end
			AU_SHR: r = a >> s;
			AU_SHL: r = a << s;
			AU_ROR:
			begin
				for (int i = 0; i < 32; i++)
					r[i] = a[(i + s) % 32];
			end
			AU_ROL:
			begin
				for (int i = 0; i < 32; i++)
					r[(i + s) % 32] = a[i];
			end
			AU_PCNT, AU_PCNTZ:
			begin
				for (int i = 0; i < 32; i++)
					n += (a[i] == (op == AU_PCNT));
				r = n;
			end
			AU_PCNTC:
			begin
				for (int i = 0; i < 31; i++)
					n += (a[i] != a[i + 1]);
				r = n;
			end
			AU_RND:
			begin
				r = lfsr_model;
				lfsr_model = lfsr_next(lfsr_model);
			end
			default: r = '0; // Divide and modulo
		endcase
	endfunction

	// ----------------------------------------------------------------------
	// Compare tasks
	// ----------------------------------------------------------------------
	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic check_rd(input string name, input reg_idx_t got, input reg_idx_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_carry(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	// Results checked away from the driving edge
	always @(negedge clk)
	begin
		if (!rst && result_valid)
		begin
			if (exp_data_q.size() == 0)
			begin
				errors++;
				$display("Unexpected result for register %0d with nothing issued", result_rd);
			end
			else
			begin
				check_word("result", result, exp_data_q.pop_front());
				check_rd("result_rd", result_rd, exp_rd_q.pop_front());
				check_carry("carry", carry, exp_carry_q.pop_front());
			end
		end
	end

	// ----------------------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------------------
	task automatic issue_instr(input au_op_e op, input reg_idx_t rd, input reg_idx_t ra,
			input reg_idx_t rb);
		word_t r;
		logic c;
		@(posedge clk);
		load_valid  <= 1'b0;
		issue_valid <= 1'b1;
		issue_op    <= op;
		issue_rd    <= rd;
		issue_ra    <= ra;
		issue_rb    <= rb;
		model_exec(op, model_regs[ra], model_regs[rb], r, c);
		if (rd != '0)
			model_regs[rd] = r;
		exp_data_q.push_back(r);
		exp_rd_q.push_back(rd);
		exp_carry_q.push_back(c);
	endtask

	task automatic load_reg(input reg_idx_t rd, input word_t data);
		@(posedge clk);
		issue_valid <= 1'b0;
		load_valid  <= 1'b1;
		load_rd     <= rd;
		load_data   <= data;
		if (rd != '0)
			model_regs[rd] = data;
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		issue_valid <= 1'b0;
		load_valid  <= 1'b0;
	endtask

	task automatic wait_results();
		int waited;
		idle_cycle();
		waited = 0;
		while (exp_data_q.size() != 0 && waited < 8)
		begin
			@(posedge clk);
			waited++;
		end
		if (exp_data_q.size() != 0)
		begin
			errors++;
			$display("%0d issued instructions never produced a result", exp_data_q.size());
			exp_data_q.delete();
			exp_rd_q.delete();
			exp_carry_q.delete();
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		$display("%-24s %s, %0d errors", name, (errors == err_before) ? "ok" : "wrong",
			errors - err_before);
	endtask

	// ----------------------------------------------------------------------
	// Tests
	// ----------------------------------------------------------------------
	task automatic arith_and_carry();
		int err0;
		err0 = errors;
		load_reg(1, 32'hFFFF_FFFF);
		load_reg(2, 32'h0000_0001);
		issue_instr(AU_ADD, 3, 1, 2); // Overflow
		issue_instr(AU_SUB, 4, 2, 1); // Borrow
		issue_instr(AU_SUB, 5, 1, 2);
		wait_results();
		for (int i = 0; i < 6; i++)
		begin
			load_reg(6, $urandom);
			load_reg(7, $urandom);
			issue_instr(AU_ADD, 8, 6, 7);
			issue_instr(AU_SUB, 9, 6, 7);
		end
		wait_results();
		report_test("arith_and_carry", err0);
	endtask

	task automatic mul_shift_rotate();
		int err0;
		word_t amounts [4];
		err0 = errors;
		amounts = '{32'd0, 32'd1, 32'd31, $urandom};
		load_reg(1, $urandom | 32'h8000_0000); // Negative
		load_reg(2, $urandom & 32'h7FFF_FFFF);
		load_reg(3, $urandom);
		issue_instr(AU_MUL, 4, 1, 2);
		issue_instr(AU_MUL, 5, 1, 1);
		issue_instr(AU_MUL, 6, 2, 3);
		issue_instr(AU_UMUL, 7, 1, 3);
		foreach (amounts[k])
		begin
			load_reg(8, amounts[k]);
			issue_instr(AU_SHR, 9, 3, 8);
			issue_instr(AU_SHL, 10, 3, 8);
			issue_instr(AU_ROR, 11, 3, 8);
			issue_instr(AU_ROL, 12, 3, 8);
		end
		wait_results();
		report_test("mul_shift_rotate", err0);
	endtask

	task automatic popcount_and_disabled();
		int err0;
		word_t pats [6];
		err0 = errors;
		pats = '{32'h0, 32'hFFFF_FFFF, 32'hAAAA_AAAA, 32'h5555_5555, $urandom, $urandom};
		foreach (pats[k])
		begin
			load_reg(1, pats[k]);
			issue_instr(AU_PCNT, 2, 1, 0);
			issue_instr(AU_PCNTZ, 3, 1, 0);
			issue_instr(AU_PCNTC, 4, 1, 0);
		end
		load_reg(5, $urandom);
		load_reg(6, $urandom);
		issue_instr(AU_DIV, 7, 5, 6);
		issue_instr(AU_UDIV, 8, 5, 6);
		issue_instr(AU_MOD, 9, 5, 6);
		issue_instr(AU_UMOD, 10, 5, 6);
		wait_results();
		report_test("popcount_and_disabled", err0);
	endtask

	task automatic random_sequence();
		int err0;
		err0 = errors;
		for (int i = 0; i < 4; i++)
		begin
			issue_instr(AU_RND, 1, 0, 0);
			issue_instr(AU_RND, 2, 0, 0);
			issue_instr(AU_ADD, 3, 1, 2);
			idle_cycle();
			issue_instr(AU_RND, 4, 0, 0);
			issue_instr(AU_SUB, 5, 4, 3);
		end
		wait_results();
		report_test("random_sequence", err0);
	endtask

	task automatic bypass_back_to_back();
		int err0;
		err0 = errors;
		load_reg(1, $urandom);
		load_reg(2, $urandom);
		issue_instr(AU_ADD, 3, 1, 2);
		issue_instr(AU_ADD, 4, 3, 1); // From the AU stage
		issue_instr(AU_ADD, 5, 4, 4);
		idle_cycle();
		issue_instr(AU_SUB, 6, 5, 3); // From the writeback
		issue_instr(AU_UMUL, 7, 6, 6);
		issue_instr(AU_ROL, 8, 7, 6);
		issue_instr(AU_PCNT, 9, 8, 0);
		wait_results();
		report_test("bypass_back_to_back", err0);
	endtask

	task automatic register_rules();
		int err0;
		word_t saved;
		err0 = errors;
		load_reg(0, 32'hDEAD_BEEF);
		load_reg(1, $urandom);
		issue_instr(AU_ADD, 0, 1, 1);
		issue_instr(AU_ADD, 2, 0, 1); // No bypass for register zero
		issue_instr(AU_SUB, 3, 0, 0);
		wait_results();
		issue_instr(AU_ADD, 4, 1, 1);
		idle_cycle();
		saved = model_regs[4];
		load_reg(4, ~saved); // Same cycle as the writeback of r4
		model_regs[4] = saved;
		issue_instr(AU_ADD, 5, 4, 0);
		wait_results();
		report_test("register_rules", err0);
	endtask

	// ----------------------------------------------------------------------
	// Run control
	// ----------------------------------------------------------------------
	initial
	begin
		void'($urandom(6));
		rst         = 1'b1;
		issue_valid = 1'b0;
		issue_op    = AU_ADD;
		issue_rd    = '0;
		issue_ra    = '0;
		issue_rb    = '0;
		load_valid  = 1'b0;
		load_rd     = '0;
		load_data   = '0;
		foreach (model_regs[i])
			model_regs[i] = '0;
		lfsr_model = LFSR_SEED;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		arith_and_carry();
		mul_shift_rotate();
		popcount_and_disabled();
		random_sequence();
		bypass_back_to_back();
		register_rules();
		$display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
			prop_fails);
		if (errors == 0 && prop_fails == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== au_pipe_top.f ====
common/au_pkg.sv
common/au_issue_if.sv
verilog/reg_file.sv
verilog/issue_stage.sv
au/rnd_lfsr.sv
au/au.sv
verilog/au_pipe_top.sv
dv/au_pipe_properties.sv
dv/au_pipe_tb.sv

// ==== Bender.yml ====
package:
  name: au_pipe

sources:
  - common/au_pkg.sv
  - common/au_issue_if.sv
  - verilog/reg_file.sv
  - verilog/issue_stage.sv
  - au/rnd_lfsr.sv
  - au/au.sv
  - verilog/au_pipe_top.sv
  - target: test
    files:
      - dv/au_pipe_properties.sv
      - dv/au_pipe_tb.sv
